// File: source/ctrl_isa_pkg.sv
////////////////////////////////////////////////////////////
// architectural encodings for the trap controller
// instruction class, fetch pc select, exception vector
// select, cause codes and interrupt id width
////////////////////////////////////////////////////////////

`default_nettype none

package ctrl_isa_pkg;

  // interrupt id width, low bits of an interrupt cause
  localparam int unsigned IRQ_ID_W = 5;

  // class of a decoded instruction, binary coded
  typedef enum logic [2:0] {
    CLS_PLAIN   = 3'd0,
    CLS_JUMP    = 3'd1,
    CLS_ECALL   = 3'd2,
    CLS_ILLEGAL = 3'd3,
    CLS_MRET    = 3'd4,
    CLS_EBREAK  = 3'd5
  } insn_class_e;

  // source of the next fetch pc
  typedef enum logic [1:0] {
    PC_BOOT      = 2'd0,
    PC_JUMP      = 2'd1,
    PC_EXCEPTION = 2'd2,
    PC_ERET      = 2'd3
  } pc_sel_e;

  // vector used when pc_sel is exception
  typedef enum logic [1:0] {
    EXC_PC_IRQ        = 2'd0,
    EXC_PC_ILLINSN    = 2'd1,
    EXC_PC_ECALL      = 2'd2,
    EXC_PC_BREAKPOINT = 2'd3
  } exc_pc_sel_e;

  // top bit marks an interrupt, low five bits hold id or code
  typedef logic [5:0] exc_cause_t;

  localparam exc_cause_t CAUSE_ILLEGAL    = 6'd2;
  localparam exc_cause_t CAUSE_BREAKPOINT = 6'd3;
  localparam exc_cause_t CAUSE_ECALL_M    = 6'd11;

endpackage

`default_nettype wire

// File: source/ctrl_bus_pkg.sv
////////////////////////////////////////////////////////////
// packed records passed between controller blocks
// decoder flags, classified descriptor, redirect record
// and default queue depths
////////////////////////////////////////////////////////////

`default_nettype none

package ctrl_bus_pkg;

  // raw flags from the decoder, one per condition
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic ebrk;
    logic branch_set;
    logic jump_set;
  } dec_flags_t;

  // classified instruction as held in the instruction queue
  typedef struct packed {
    ctrl_isa_pkg::insn_class_e cls;
  } insn_desc_t;

  // one pc redirect with its csr side effects
  typedef struct packed {
    ctrl_isa_pkg::pc_sel_e     pc_sel;
    ctrl_isa_pkg::exc_pc_sel_e exc_pc_sel;
    ctrl_isa_pkg::exc_cause_t  cause;
    // save fetch pc (interrupt) or decode pc (exception)
    logic                      save_if;
    logic                      save_id;
    logic                      save_cause;
    logic                      restore_mret;
  } redirect_t;

  localparam int unsigned INSN_DEPTH_DEF  = 4;
  localparam int unsigned REDIR_DEPTH_DEF = 4;

endpackage

`default_nettype wire

// File: source/insn_classifier.sv
////////////////////////////////////////////////////////////
// instruction classifier
// one register stage that priority-encodes decoder flags
// into a descriptor, valid/ready on both sides
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module insn_classifier (
  input  logic                     clk,
  input  logic                     rst_n,
  // decoder side
  input  logic                     in_valid_i,
  input  ctrl_bus_pkg::dec_flags_t in_flags_i,
  output logic                     in_ready_o,
  // descriptor side
  output logic                     out_valid_o,
  output ctrl_bus_pkg::insn_desc_t out_desc_o,
  input  logic                     out_ready_i
);

  logic                     valid_q;
  ctrl_bus_pkg::insn_desc_t desc_q;
  logic                     accept;

  // jump wins over every exception flag, then ecall, illegal, mret, ebreak
  function automatic ctrl_isa_pkg::insn_class_e classify(ctrl_bus_pkg::dec_flags_t f);
    ctrl_isa_pkg::insn_class_e cls;
    if (f.branch_set || f.jump_set) begin
      cls = ctrl_isa_pkg::CLS_JUMP;
    end else if (f.ecall) begin
      cls = ctrl_isa_pkg::CLS_ECALL;
    end else if (f.illegal) begin
      cls = ctrl_isa_pkg::CLS_ILLEGAL;
    end else if (f.mret) begin
      cls = ctrl_isa_pkg::CLS_MRET;
    end else if (f.ebrk) begin
      cls = ctrl_isa_pkg::CLS_EBREAK;
    end else begin
      cls = ctrl_isa_pkg::CLS_PLAIN;
    end
    return cls;
  endfunction

  // stage takes a new entry when empty or when it drains this cycle
  assign in_ready_o = ~valid_q | out_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // payload register, only loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      desc_q.cls <= classify(in_flags_i);
    end
  end

  assign out_valid_o = valid_q;
  assign out_desc_o  = desc_q;

endmodule

`default_nettype wire

// File: source/ctrl_fifo.sv
////////////////////////////////////////////////////////////
// synchronous valid/ready queue
// circular buffer with type-parameter payload
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  // write side
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  // read side
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  // wrap explicitly so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // full blocks writes, empty hides the head entry
  assign in_ready_o  = (cnt_q != CNT_W'(DEPTH));
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // count only moves when exactly one side transfers
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/trap_fsm.sv
////////////////////////////////////////////////////////////
// trap sequencer
// boot, decode, flush and interrupt FSM that consumes
// descriptors and writes redirect records
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_fsm (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  fetch_enable_i,
  // descriptor input
  input  logic                                  desc_valid_i,
  input  ctrl_bus_pkg::insn_desc_t              desc_i,
  output logic                                  desc_ready_o,
  // interrupt request
  input  logic                                  irq_req_i,
  input  logic [ctrl_isa_pkg::IRQ_ID_W-1:0]     irq_id_i,
  input  logic                                  m_ie_i,
  // redirect record output
  output logic                                  rec_valid_o,
  output ctrl_bus_pkg::redirect_t               rec_o,
  input  logic                                  rec_ready_i,
  output logic                                  irq_ack_o,
  output logic                                  ctrl_busy_o
);

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  ctrl_state_e               state_q;
  ctrl_state_e               state_d;
  // class of the instruction waiting in FLUSH
  ctrl_isa_pkg::insn_class_e cls_q;
  logic                      cls_load;

  // exception and mret records, everything not listed stays zero
  function automatic ctrl_bus_pkg::redirect_t flush_rec(ctrl_isa_pkg::insn_class_e cls);
    ctrl_bus_pkg::redirect_t r;
    r = '0;
    case (cls)
      ctrl_isa_pkg::CLS_ECALL: begin
        r.pc_sel     = ctrl_isa_pkg::PC_EXCEPTION;
        r.exc_pc_sel = ctrl_isa_pkg::EXC_PC_ECALL;
        r.cause      = ctrl_isa_pkg::CAUSE_ECALL_M;
        r.save_id    = 1'b1;
        r.save_cause = 1'b1;
      end
      ctrl_isa_pkg::CLS_ILLEGAL: begin
        r.pc_sel     = ctrl_isa_pkg::PC_EXCEPTION;
        r.exc_pc_sel = ctrl_isa_pkg::EXC_PC_ILLINSN;
        r.cause      = ctrl_isa_pkg::CAUSE_ILLEGAL;
        r.save_id    = 1'b1;
        r.save_cause = 1'b1;
      end
      ctrl_isa_pkg::CLS_EBREAK: begin
        // plain breakpoint exception, epc is the ebreak itself
        r.pc_sel     = ctrl_isa_pkg::PC_EXCEPTION;
        r.exc_pc_sel = ctrl_isa_pkg::EXC_PC_BREAKPOINT;
        r.cause      = ctrl_isa_pkg::CAUSE_BREAKPOINT;
        r.save_id    = 1'b1;
        r.save_cause = 1'b1;
      end
      default: begin
        // mret, return through mepc
        r.pc_sel       = ctrl_isa_pkg::PC_ERET;
        r.restore_mret = 1'b1;
      end
    endcase
    return r;
  endfunction

  assign ctrl_busy_o = (state_q != RESET);

  ////////////////////////////////////////////////////////////
  // next state and record
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    desc_ready_o = 1'b0;
    rec_valid_o  = 1'b0;
    rec_o        = '0;
    irq_ack_o    = 1'b0;
    cls_load     = 1'b0;

    case (state_q)
      // wait for fetch enable
      RESET: begin
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // boot redirect, held until the redirect queue takes it
      BOOT_SET: begin
        rec_valid_o  = 1'b1;
        rec_o.pc_sel = ctrl_isa_pkg::PC_BOOT;
        if (rec_ready_i) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        state_d = DECODE;
      end

      DECODE: begin
        if (irq_req_i && m_ie_i) begin
          // interrupt goes first, the head descriptor stays queued
          state_d = IRQ_TAKEN;
        end else if (desc_valid_i) begin
          case (desc_i.cls)
            ctrl_isa_pkg::CLS_PLAIN: begin
              desc_ready_o = 1'b1;
            end
            ctrl_isa_pkg::CLS_JUMP: begin
              // pop only once the record is accepted
              rec_valid_o  = 1'b1;
              rec_o.pc_sel = ctrl_isa_pkg::PC_JUMP;
              desc_ready_o = rec_ready_i;
            end
            default: begin
              desc_ready_o = 1'b1;
              cls_load     = 1'b1;
              state_d      = FLUSH;
            end
          endcase
        end
      end

      // exception or mret record from the saved class
      FLUSH: begin
        rec_valid_o = 1'b1;
        rec_o       = flush_rec(cls_q);
        if (rec_ready_i) begin
          state_d = DECODE;
        end
      end

      // requester holds id until ack, so the record stays stable
      IRQ_TAKEN: begin
        rec_valid_o      = 1'b1;
        rec_o.pc_sel     = ctrl_isa_pkg::PC_EXCEPTION;
        rec_o.exc_pc_sel = ctrl_isa_pkg::EXC_PC_IRQ;
        rec_o.cause      = {1'b1, irq_id_i};
        rec_o.save_if    = 1'b1;
        rec_o.save_cause = 1'b1;
        if (rec_ready_i) begin
          irq_ack_o = 1'b1;
          state_d   = DECODE;
        end
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (cls_load) begin
      cls_q <= desc_i.cls;
    end
  end

endmodule

`default_nettype wire

// File: source/trap_ctrl.sv
////////////////////////////////////////////////////////////
// trap controller top level
// classifier, instruction queue, sequencer, redirect queue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_ctrl #(
  parameter int unsigned INSN_DEPTH  = ctrl_bus_pkg::INSN_DEPTH_DEF,
  parameter int unsigned REDIR_DEPTH = ctrl_bus_pkg::REDIR_DEPTH_DEF
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              fetch_enable_i,
  // instruction input
  input  logic                              insn_valid_i,
  input  ctrl_bus_pkg::dec_flags_t          insn_flags_i,
  output logic                              insn_ready_o,
  // interrupts
  input  logic                              irq_req_i,
  input  logic [ctrl_isa_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                              m_ie_i,
  output logic                              irq_ack_o,
  // redirect output
  output logic                              redir_valid_o,
  output ctrl_bus_pkg::redirect_t           redir_o,
  input  logic                              redir_ready_i,
  output logic                              ctrl_busy_o
);

  // classifier to instruction queue
  logic                     cls_valid;
  ctrl_bus_pkg::insn_desc_t cls_desc;
  logic                     cls_ready;
  // instruction queue to sequencer
  logic                     desc_valid;
  ctrl_bus_pkg::insn_desc_t desc;
  logic                     desc_ready;
  // sequencer to redirect queue
  logic                     rec_valid;
  ctrl_bus_pkg::redirect_t  rec;
  logic                     rec_ready;

  insn_classifier u_classifier (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (insn_valid_i),
    .in_flags_i  (insn_flags_i),
    .in_ready_o  (insn_ready_o),
    .out_valid_o (cls_valid),
    .out_desc_o  (cls_desc),
    .out_ready_i (cls_ready)
  );

  ctrl_fifo #(
    .payload_t (ctrl_bus_pkg::insn_desc_t),
    .DEPTH     (INSN_DEPTH)
  ) u_insn_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (cls_valid),
    .in_data_i   (cls_desc),
    .in_ready_o  (cls_ready),
    .out_valid_o (desc_valid),
    .out_data_o  (desc),
    .out_ready_i (desc_ready)
  );

  trap_fsm u_trap_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .desc_valid_i   (desc_valid),
    .desc_i         (desc),
    .desc_ready_o   (desc_ready),
    .irq_req_i      (irq_req_i),
    .irq_id_i       (irq_id_i),
    .m_ie_i         (m_ie_i),
    .rec_valid_o    (rec_valid),
    .rec_o          (rec),
    .rec_ready_i    (rec_ready),
    .irq_ack_o      (irq_ack_o),
    .ctrl_busy_o    (ctrl_busy_o)
  );

  ctrl_fifo #(
    .payload_t (ctrl_bus_pkg::redirect_t),
    .DEPTH     (REDIR_DEPTH)
  ) u_redir_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (rec_valid),
    .in_data_i   (rec),
    .in_ready_o  (rec_ready),
    .out_valid_o (redir_valid_o),
    .out_data_o  (redir_o),
    .out_ready_i (redir_ready_i)
  );

endmodule

`default_nettype wire

// File: bench/trap_ctrl_checker.sv
////////////////////////////////////////////////////////////
// concurrent assertions on the trap_ctrl handshakes
// bound into every trap_ctrl instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_ctrl_checker (
  input wire logic                     clk,
  input wire logic                     rst_n,
  input wire logic                     fetch_enable_i,
  input wire logic                     insn_valid_i,
  input wire ctrl_bus_pkg::dec_flags_t insn_flags_i,
  input wire logic                     insn_ready_o,
  input wire logic                     irq_ack_o,
  input wire logic                     redir_valid_o,
  input wire ctrl_bus_pkg::redirect_t  redir_o,
  input wire logic                     redir_ready_i
);

  // failed assertions, read by the testbench at the end
  int   fail_count = 0;
  logic fe_seen_q;

  // sticky once fetch enable has been high on a clock edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fe_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fe_seen_q <= 1'b1;
    end
  end

  // held redirect keeps valid and payload
  redir_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    redir_valid_o && !redir_ready_i |=> redir_valid_o && $stable(redir_o))
  else begin
    $error("redirect output changed while stalled");
    fail_count++;
  end

  // ack is a single cycle pulse
  ack_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |=> !irq_ack_o)
  else begin
    $error("interrupt ack longer than one cycle");
    fail_count++;
  end

  // nothing leaves before boot was enabled
  no_early_redir_a: assert property (@(posedge clk) disable iff (!rst_n)
    !fe_seen_q |-> !redir_valid_o)
  else begin
    $error("redirect valid before fetch enable");
    fail_count++;
  end

  // decoder side must hold its flags while stalled
  flags_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    insn_valid_i && !insn_ready_o |=> insn_valid_i && $stable(insn_flags_i))
  else begin
    $error("instruction flags changed while stalled");
    fail_count++;
  end

endmodule

bind trap_ctrl trap_ctrl_checker u_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .fetch_enable_i (fetch_enable_i),
  .insn_valid_i   (insn_valid_i),
  .insn_flags_i   (insn_flags_i),
  .insn_ready_o   (insn_ready_o),
  .irq_ack_o      (irq_ack_o),
  .redir_valid_o  (redir_valid_o),
  .redir_o        (redir_o),
  .redir_ready_i  (redir_ready_i)
);

`default_nettype wire

// File: bench/trap_ctrl_tb.sv
////////////////////////////////////////////////////////////
// testbench for trap_ctrl
// seeded random instructions and interrupts, reference
// model of the redirect records, watchdog and verdict
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trap_ctrl_tb;

  localparam int CLK_PERIOD  = 10;
  localparam int N_INSN      = 300;
  localparam int WDOG_CYCLES = N_INSN * 20 + 2000;
  localparam int ID_W        = ctrl_isa_pkg::IRQ_ID_W;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     fetch_enable_i;
  logic                     insn_valid_i;
  ctrl_bus_pkg::dec_flags_t insn_flags_i;
  logic                     insn_ready_o;
  logic                     irq_req_i;
  logic [ID_W-1:0]          irq_id_i;
  logic                     m_ie_i;
  logic                     irq_ack_o;
  logic                     redir_valid_o;
  ctrl_bus_pkg::redirect_t  redir_o;
  logic                     redir_ready_i;
  logic                     ctrl_busy_o;

  integer seed = 32'hb894;
  int     value_errors = 0;
  int     proto_errors = 0;
  // bookkeeping shared by the processes below
  bit     fe_seen = 1'b0;
  bit     boot_seen = 1'b0;
  bit     stim_done = 1'b0;
  bit     irq_done = 1'b0;
  int     model_count = 0;
  int     nonirq_count = 0;
  int     ack_count = 0;
  // expected non-interrupt records in order
  ctrl_bus_pkg::redirect_t exp_q[$];
  // ids of acked interrupts whose record is still in flight
  logic [ID_W-1:0]         irq_q[$];

  always #(CLK_PERIOD / 2) clk = ~clk;

  trap_ctrl #(
    .INSN_DEPTH  (ctrl_bus_pkg::INSN_DEPTH_DEF),
    .REDIR_DEPTH (ctrl_bus_pkg::REDIR_DEPTH_DEF)
  ) trap_ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .insn_valid_i   (insn_valid_i),
    .insn_flags_i   (insn_flags_i),
    .insn_ready_o   (insn_ready_o),
    .irq_req_i      (irq_req_i),
    .irq_id_i       (irq_id_i),
    .m_ie_i         (m_ie_i),
    .irq_ack_o      (irq_ack_o),
    .redir_valid_o  (redir_valid_o),
    .redir_o        (redir_o),
    .redir_ready_i  (redir_ready_i),
    .ctrl_busy_o    (ctrl_busy_o)
  );

  ////////////////////////////////////////////////////////////
  // checks and reference model
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAIL t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, expected);
      value_errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    proto_errors++;
  endtask

  task automatic print_counts();
    $display("errors: value %0d, protocol %0d, assertion %0d",
             value_errors, proto_errors, trap_ctrl_i.u_checker.fail_count);
  endtask

  function automatic ctrl_bus_pkg::redirect_t boot_record();
    ctrl_bus_pkg::redirect_t r;
    r        = '0;
    r.pc_sel = ctrl_isa_pkg::PC_BOOT;
    return r;
  endfunction

  // synchronous exception saves the decode pc
  function automatic ctrl_bus_pkg::redirect_t exc_record(ctrl_isa_pkg::exc_pc_sel_e vec,
                                                         ctrl_isa_pkg::exc_cause_t cause);
    ctrl_bus_pkg::redirect_t r;
    r            = '0;
    r.pc_sel     = ctrl_isa_pkg::PC_EXCEPTION;
    r.exc_pc_sel = vec;
    r.cause      = cause;
    r.save_id    = 1'b1;
    r.save_cause = 1'b1;
    return r;
  endfunction

  // interrupt saves the fetch pc and sets the top cause bit
  function automatic ctrl_bus_pkg::redirect_t irq_record(logic [ID_W-1:0] id);
    ctrl_bus_pkg::redirect_t r;
    r            = '0;
    r.pc_sel     = ctrl_isa_pkg::PC_EXCEPTION;
    r.exc_pc_sel = ctrl_isa_pkg::EXC_PC_IRQ;
    r.cause      = {1'b1, id};
    r.save_if    = 1'b1;
    r.save_cause = 1'b1;
    return r;
  endfunction

  // jump first, then ecall, illegal, mret and ebreak
  // plain instructions emit nothing
  task automatic model_accept(input ctrl_bus_pkg::dec_flags_t f);
    ctrl_bus_pkg::redirect_t r;
    bit                      emits;
    r     = '0;
    emits = 1'b1;
    if (f.branch_set || f.jump_set) begin
      r.pc_sel = ctrl_isa_pkg::PC_JUMP;
    end else if (f.ecall) begin
      r = exc_record(ctrl_isa_pkg::EXC_PC_ECALL, ctrl_isa_pkg::CAUSE_ECALL_M);
    end else if (f.illegal) begin
      r = exc_record(ctrl_isa_pkg::EXC_PC_ILLINSN, ctrl_isa_pkg::CAUSE_ILLEGAL);
    end else if (f.mret) begin
      r.pc_sel       = ctrl_isa_pkg::PC_ERET;
      r.restore_mret = 1'b1;
    end else if (f.ebrk) begin
      r = exc_record(ctrl_isa_pkg::EXC_PC_BREAKPOINT, ctrl_isa_pkg::CAUSE_BREAKPOINT);
    end else begin
      emits = 1'b0;
    end
    if (emits) begin
      exp_q.push_back(r);
      model_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // each flag set about one time in eight so roughly half the sets are plain
  function automatic logic rare_flag();
    return (($random(seed) & 7) == 0);
  endfunction

  function automatic ctrl_bus_pkg::dec_flags_t random_flags();
    ctrl_bus_pkg::dec_flags_t f;
    f.illegal    = rare_flag();
    f.ecall      = rare_flag();
    f.mret       = rare_flag();
    f.ebrk       = rare_flag();
    f.branch_set = rare_flag();
    f.jump_set   = rare_flag();
    return f;
  endfunction

  // step to 1 ns after the n-th rising edge
  task automatic wait_cycles(input int n);
    if (n > 0) begin
      repeat (n) @(posedge clk);
      #1;
    end
  endtask

  // hold valid and flags until the classifier takes them
  task automatic send_insn(input ctrl_bus_pkg::dec_flags_t f);
    insn_valid_i = 1'b1;
    insn_flags_i = f;
    @(negedge clk);
    while (!insn_ready_o) begin
      @(negedge clk);
    end
    model_accept(f);
    wait_cycles(1);
    insn_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // processes
  ////////////////////////////////////////////////////////////

  // main sequence through reset, boot, instructions, drain and verdict
  initial begin : main_seq
    int drain;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    insn_valid_i   = 1'b0;
    insn_flags_i   = '0;
    wait_cycles(10);
    rst_n = 1'b1;
    wait_cycles(1);
    // reset state
    check_value("redir_valid_o", 32'(redir_valid_o), 32'd0);
    check_value("irq_ack_o", 32'(irq_ack_o), 32'd0);
    check_value("ctrl_busy_o", 32'(ctrl_busy_o), 32'd0);
    check_value("insn_ready_o", 32'(insn_ready_o), 32'd1);
    // idle so the monitor can flag any early record
    wait_cycles(5);
    fe_seen        = 1'b1;
    fetch_enable_i = 1'b1;
    for (int i = 0; i < N_INSN; i++) begin
      send_insn(random_flags());
      wait_cycles({$random(seed)} % 4);
    end
    stim_done = 1'b1;
    wait (irq_done);
    wait_cycles(1);
    // bounded wait for queued records to drain
    drain = 0;
    while ((exp_q.size() != 0 || irq_q.size() != 0) && drain < 500) begin
      wait_cycles(1);
      drain++;
    end
    // extra cycles catch duplicated records
    wait_cycles(20);
    check_value("ctrl_busy_o", 32'(ctrl_busy_o), 32'd1);
    check_value("record_count", 32'(nonirq_count), 32'(model_count));
    check_value("model_queue_size", 32'(exp_q.size()), 32'd0);
    check_value("irq_queue_size", 32'(irq_q.size()), 32'd0);
    if (!boot_seen) begin
      report_problem("no boot record was seen");
    end
    print_counts();
    if (value_errors == 0 && proto_errors == 0 && trap_ctrl_i.u_checker.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // interrupt requester that changes m_ie only between requests
  initial begin : irq_seq
    int acks_before;
    irq_req_i = 1'b0;
    irq_id_i  = '0;
    m_ie_i    = 1'b0;
    wait (fe_seen);
    wait_cycles(10);
    while (!stim_done) begin
      wait_cycles(5 + ({$random(seed)} % 32));
      m_ie_i      = (($random(seed) & 3) != 0);
      irq_id_i    = ID_W'($random(seed));
      acks_before = ack_count;
      irq_req_i   = 1'b1;
      if (m_ie_i) begin
        // enabled requests must be acked
        @(negedge clk);
        while (!irq_ack_o) begin
          @(negedge clk);
        end
        wait_cycles(1);
        irq_req_i = 1'b0;
        // a repeated ack in the following cycles shows up in the count
        wait_cycles(2);
        check_value("irq_ack_count", 32'(ack_count - acks_before), 32'd1);
      end else begin
        wait_cycles(40);
        irq_req_i = 1'b0;
        check_value("irq_ack_count", 32'(ack_count - acks_before), 32'd0);
      end
    end
    irq_done = 1'b1;
  end

  // output back-pressure with ready low about 30% of cycles
  initial begin : ready_seq
    redir_ready_i = 1'b0;
    forever begin
      wait_cycles(1);
      redir_ready_i = (({$random(seed)} % 10) >= 3);
    end
  end

  // monitor samples at the falling edge where inputs and outputs are settled
  initial begin : monitor
    ctrl_bus_pkg::redirect_t exp;
    logic [ID_W-1:0]         id;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (irq_ack_o) begin
          if (!irq_req_i) begin
            report_problem("interrupt ack without a pending request");
          end
          irq_q.push_back(irq_id_i);
          ack_count++;
        end
        if (redir_valid_o && !fe_seen) begin
          report_problem("redirect output valid before fetch enable");
        end
        if (redir_valid_o && redir_ready_i) begin
          if (!boot_seen) begin
            // first record of the run is always boot
            check_value("redir_o", 32'(redir_o), 32'(boot_record()));
            boot_seen = 1'b1;
          end else if (redir_o.cause[5]) begin
            if (irq_q.size() == 0) begin
              report_problem("interrupt record without a preceding ack");
            end else begin
              id = irq_q.pop_front();
              check_value("redir_o", 32'(redir_o), 32'(irq_record(id)));
            end
          end else begin
            nonirq_count++;
            if (exp_q.size() == 0) begin
              report_problem("redirect record with no matching instruction");
            end else begin
              exp = exp_q.pop_front();
              check_value("redir_o", 32'(redir_o), 32'(exp));
            end
          end
        end
      end
    end
  end

  // watchdog sized from the instruction count
  initial begin : watchdog
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("timeout: simulation did not finish within %0d cycles", WDOG_CYCLES);
    print_counts();
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: trap_ctrl.f
source/ctrl_isa_pkg.sv
source/ctrl_bus_pkg.sv
source/insn_classifier.sv
source/ctrl_fifo.sv
source/trap_fsm.sv
source/trap_ctrl.sv
bench/trap_ctrl_checker.sv
bench/trap_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build and run the trap_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module trap_ctrl_tb -f trap_ctrl.f -o Vtrap_ctrl_tb

./obj_dir/Vtrap_ctrl_tb +verilator+error+limit+1000 2>&1 | tee sim.log

# verdict comes from the log, not from the exit status
if grep -qx '>>> PASS' sim.log; then
  exit 0
fi
exit 1
